/* project.f */
+incdir+hdl
+incdir+test
hdl/mbox_bus_pkg.sv
hdl/mbox_state_pkg.sv
hdl/mbox_fsm.sv
hdl/mbox_buffer.sv
hdl/mbox_regs.sv
hdl/mbox_top.sv
test/tb_mbox.sv

/* Makefile */
# Verilator build and run of the mailbox testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_mbox
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_mbox_tasks.svh */
// bus access tasks, the value check and the directed mailbox tests
// included inside the testbench module body

// every error ends the run right away
task automatic stop_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check(input string what, input logic [31:0] expected,
                     input logic [31:0] actual);
    if (expected !== actual) begin
        stop_run($sformatf("CHECK FAILED test %s (%s) expected 0x%08h actual 0x%08h",
                           test_name, what, expected, actual));
    end
endtask

// one request strobe, then wait for the response between clock edges
task automatic bus_access(input mbox_side_e side, input logic write,
                          input logic [`MBOX_ADDR_W-1:0] addr,
                          input logic [`MBOX_DATA_W-1:0] wd);
    int waited;
    waited = 0;
    @(posedge clk);
    req_dv    <= 1'b1;
    req_write <= write;
    req_addr  <= addr;
    req_wdata <= wd;
    soc_req   <= side;
    @(posedge clk);
    req_dv <= 1'b0;
    do begin
        @(negedge clk);
        waited = waited + 1;
        if (waited > rsp_timeout) begin
            stop_run("the mailbox gave no response strobe for a bus request");
        end
    end while (!rsp_dv);
    last_rdata = rdata;
    last_err   = mbox_error;
endtask

// valid accesses must never raise the error flag
task automatic reg_write(input mbox_side_e side, input logic [`MBOX_ADDR_W-1:0] addr,
                         input logic [`MBOX_DATA_W-1:0] wd);
    bus_access(side, 1'b1, addr, wd);
    check("error flag on write", 32'd0, 32'(last_err));
endtask

task automatic reg_read(input mbox_side_e side, input logic [`MBOX_ADDR_W-1:0] addr,
                        output logic [`MBOX_DATA_W-1:0] value);
    bus_access(side, 1'b0, addr, '0);
    check("error flag on read", 32'd0, 32'(last_err));
    value = last_rdata;
endtask

// status layout is the code in bits 3:0, the state in 6:4 and the SoC lock bit in 7
function automatic logic [31:0] expected_status(input logic lock_soc,
                                                input mbox_fsm_state_e st,
                                                input mbox_cmd_status_e code);
    return {24'b0, lock_soc, st, code};
endfunction

task automatic check_status(input string what, input logic lock_soc,
                            input mbox_fsm_state_e st, input mbox_cmd_status_e code);
    logic [`MBOX_DATA_W-1:0] value;
    reg_read(SIDE_SOC, `MBOX_OFS_STATUS, value);
    check(what, expected_status(lock_soc, st, code), value);
endtask

task automatic check_avail(input logic uc_exp, input logic soc_exp);
    check("uc data available", 32'(uc_exp), 32'(uc_data_avail));
    check("soc data available", 32'(soc_exp), 32'(soc_data_avail));
endtask

// a free mailbox answers the winning lock read with 0
task automatic take_lock(input mbox_side_e side);
    logic [`MBOX_DATA_W-1:0] value;
    reg_read(side, `MBOX_OFS_LOCK, value);
    check("lock read", 32'd0, value);
endtask

task automatic push_word(input mbox_side_e side);
    logic [`MBOX_DATA_W-1:0] word;
    word = $random(seed);
    reg_write(side, `MBOX_OFS_DATAIN, word);
    sent_words.push_back(word);
endtask

// lock, cmd, a 10 byte length, three words and execute
task automatic send_message(input mbox_side_e side);
    logic [`MBOX_DATA_W-1:0] cmd;
    logic [`MBOX_DATA_W-1:0] value;
    cmd = $random(seed);
    sent_words.delete();
    take_lock(side);
    reg_write(side, `MBOX_OFS_CMD, cmd);
    // the command register keeps what its owner wrote
    reg_read(side, `MBOX_OFS_CMD, value);
    check("cmd read back", cmd, value);
    reg_write(side, `MBOX_OFS_DLEN, 32'd10);
    repeat (3) push_word(side);
    reg_write(side, `MBOX_OFS_EXECUTE, 32'd1);
endtask

task automatic read_back(input mbox_side_e side, input int extra);
    logic [`MBOX_DATA_W-1:0] word;
    foreach (sent_words[i]) begin
        reg_read(side, `MBOX_OFS_DATAOUT, word);
        check($sformatf("dataout word %0d", i), sent_words[i], word);
    end
    // past the length the read pointer holds, so the last word comes again
    repeat (extra) begin
        reg_read(side, `MBOX_OFS_DATAOUT, word);
        check("dataout past the end", sent_words[$], word);
    end
endtask

// clearing execute releases the mailbox back to idle
task automatic finish_transfer(input mbox_side_e side);
    reg_write(side, `MBOX_OFS_EXECUTE, 32'd0);
    check_avail(1'b0, 1'b0);
    check_status("status after release", 1'b0, MBOX_IDLE, CMD_BUSY);
endtask

task automatic test_after_reset();
    logic [`MBOX_DATA_W-1:0] value;
    test_name = "after reset";
    check_status("status after reset", 1'b0, MBOX_IDLE, CMD_BUSY);
    check_avail(1'b0, 1'b0);
    take_lock(SIDE_UC);
    reg_read(SIDE_UC, `MBOX_OFS_LOCK, value);
    check("second lock read", 32'd1, value);
    reg_write(SIDE_SOC, `MBOX_OFS_UNLOCK, 32'd1);
endtask

task automatic test_soc_to_uc();
    test_name = "soc to uc";
    send_message(SIDE_SOC);
    check_avail(1'b1, 1'b0);
    check_status("status in execute", 1'b1, MBOX_EXECUTE_UC, CMD_BUSY);
    read_back(SIDE_UC, 1);
    finish_transfer(SIDE_UC);
endtask

task automatic test_uc_to_soc();
    test_name = "uc to soc";
    send_message(SIDE_UC);
    check_avail(1'b0, 1'b1);
    check_status("status in execute", 1'b0, MBOX_EXECUTE_SOC, CMD_BUSY);
    read_back(SIDE_SOC, 1);
    reg_write(SIDE_SOC, `MBOX_OFS_STATUS, 32'(CMD_COMPLETE));
    check_status("posted status", 1'b0, MBOX_EXECUTE_SOC, CMD_COMPLETE);
    finish_transfer(SIDE_SOC);
endtask

task automatic test_ownership();
    logic [`MBOX_DATA_W-1:0] junk;
    logic [`MBOX_DATA_W-1:0] value;
    test_name = "ownership";
    junk = $random(seed);
    sent_words.delete();
    take_lock(SIDE_SOC);
    reg_write(SIDE_SOC, `MBOX_OFS_CMD, 32'h0000_00a5);
    reg_write(SIDE_SOC, `MBOX_OFS_DLEN, 32'd12);
    push_word(SIDE_SOC);
    // the uC does not own this phase, so its word must not reach the buffer
    reg_write(SIDE_UC, `MBOX_OFS_DATAIN, junk);
    repeat (2) push_word(SIDE_SOC);
    reg_write(SIDE_SOC, `MBOX_OFS_EXECUTE, 32'd1);
    // the sender may not read the message it handed over
    reg_read(SIDE_SOC, `MBOX_OFS_DATAOUT, value);
    check("sender dataout read", 32'd0, value);
    read_back(SIDE_UC, 0);
    finish_transfer(SIDE_UC);
endtask

task automatic test_force_unlock();
    test_name = "force unlock";
    take_lock(SIDE_UC);
    reg_write(SIDE_UC, `MBOX_OFS_CMD, 32'h0000_0042);
    check_status("status waiting for dlen", 1'b0, MBOX_RDY_FOR_DLEN, CMD_BUSY);
    reg_write(SIDE_SOC, `MBOX_OFS_UNLOCK, 32'd1);
    check_status("status after unlock", 1'b0, MBOX_IDLE, CMD_BUSY);
    take_lock(SIDE_SOC);
    reg_write(SIDE_SOC, `MBOX_OFS_UNLOCK, 32'd1);
endtask

task automatic test_errors();
    test_name = "errors";
    bus_access(SIDE_SOC, 1'b0, 6'h04, '0);
    check("unmapped read error", 32'd1, 32'(last_err));
    bus_access(SIDE_UC, 1'b1, 6'h24, 32'h1234_5678);
    check("unmapped write error", 32'd1, 32'(last_err));
    bus_access(SIDE_SOC, 1'b1, `MBOX_OFS_DATAOUT, 32'h0000_0001);
    check("dataout write error", 32'd1, 32'(last_err));
    bus_access(SIDE_UC, 1'b1, `MBOX_OFS_LOCK, 32'h0000_0001);
    check("lock write error", 32'd1, 32'(last_err));
    // none of the bad accesses may have disturbed the idle mailbox
    check_status("status after bad accesses", 1'b0, MBOX_IDLE, CMD_BUSY);
endtask

/* test/tb_mbox.sv */
// testbench top for the message mailbox with clock, reset, DUT and test sequence
// bus access and directed test tasks come from the included task file
`timescale 1ns/1ns

`include "mbox_consts.svh"

module tb_mbox;
    import mbox_bus_pkg::*;
    import mbox_state_pkg::*;

    // longest wait for a response strobe, in clock cycles
    localparam int rsp_timeout = 20;

    logic                    clk;
    logic                    rst_b;
    logic                    req_dv;
    logic                    req_write;
    logic [`MBOX_ADDR_W-1:0] req_addr;
    logic [`MBOX_DATA_W-1:0] req_wdata;
    logic                    soc_req;
    logic                    rsp_dv;
    logic [`MBOX_DATA_W-1:0] rdata;
    logic                    mbox_error;
    logic                    uc_data_avail;
    logic                    soc_data_avail;

    // shared state of the test tasks
    integer                  seed;
    string                   test_name;
    logic [`MBOX_DATA_W-1:0] last_rdata;
    logic                    last_err;
    // words the sender wrote, in the order the receiver must see them
    logic [`MBOX_DATA_W-1:0] sent_words[$];

    mbox_top UUT (
        .clk, .rst_b, .req_dv, .req_write, .req_addr, .req_wdata, .soc_req,
        .rsp_dv, .rdata, .mbox_error, .uc_data_avail, .soc_data_avail
    );

    // 10 ns clock period
    always #5 clk = ~clk;

    `include "tb_mbox_tasks.svh"

    initial begin
        clk         = 1'b0;
        rst_b       = 1'b0;
        req_dv      = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        soc_req     = 1'b0;
        seed        = 32'h370b4805;
        test_name   = "reset";
        last_rdata  = '0;
        last_err    = 1'b0;
        // reset held for 16 cycles, released on a rising edge
        repeat (16) @(posedge clk);
        rst_b <= 1'b1;
        repeat (2) @(posedge clk);
        test_after_reset();
        test_soc_to_uc();
        test_uc_to_soc();
        test_ownership();
        test_force_unlock();
        test_errors();
        $display("Testbench passed");
        $finish;
    end

endmodule

/* hdl/mbox_top.sv */
// mailbox top level joining the register block, protocol FSM and message buffer
`timescale 1ns/1ns

`include "mbox_consts.svh"

module mbox_top (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic                    req_dv,
    input  logic                    req_write,
    input  logic [`MBOX_ADDR_W-1:0] req_addr,
    input  logic [`MBOX_DATA_W-1:0] req_wdata,
    input  logic                    soc_req,
    output logic                    rsp_dv,
    output logic [`MBOX_DATA_W-1:0] rdata,
    output logic                    mbox_error,
    output logic                    uc_data_avail,
    output logic                    soc_data_avail
);
    import mbox_bus_pkg::*;
    import mbox_state_pkg::*;

    // request strobes from the decoder
    logic lock_rd, cmd_wr, dlen_wr, datain_wr, dataout_rd, execute_wr, unlock_wr;
    mbox_side_e              side;
    logic                    execute_val;
    logic [`MBOX_DATA_W-1:0] wdata;
    logic [31:0]             dlen_bytes;
    // protocol view returned to the register block
    mbox_fsm_state_e         state;
    logic                    soc_has_lock, locked, owner_ok, to_idle;
    // buffer controls and the word at the read pointer
    logic                    push, pop, wr_clr, rd_clr;
    logic [`MBOX_DATA_W-1:0] dataout;

    mbox_regs u_regs (
        .clk, .rst_b, .req_dv, .req_write, .req_addr, .req_wdata, .soc_req,
        .state, .soc_has_lock, .locked, .owner_ok, .pop, .to_idle, .dataout,
        .lock_rd, .cmd_wr, .dlen_wr, .datain_wr, .dataout_rd, .execute_wr, .unlock_wr,
        .side, .execute_val, .wdata, .dlen_bytes, .rsp_dv, .rdata, .mbox_error
    );

    mbox_fsm u_fsm (
        .clk, .rst_b, .lock_rd, .cmd_wr, .dlen_wr, .datain_wr, .dataout_rd,
        .execute_wr, .unlock_wr, .side, .execute_val,
        .state, .soc_has_lock, .locked, .owner_ok, .push, .pop, .wr_clr, .rd_clr,
        .to_idle, .uc_data_avail, .soc_data_avail
    );

    mbox_buffer u_buffer (
        .clk, .rst_b, .push, .pop, .wr_clr, .rd_clr, .wdata, .dlen_bytes, .dataout
    );

endmodule

/* hdl/mbox_regs.sv */
// register bus decoder with the cmd, dlen and status registers
// builds the registered response with read data and error flag
`timescale 1ns/1ns

`include "mbox_consts.svh"

module mbox_regs (
    input  logic                             clk,
    input  logic                             rst_b,
    input  logic                             req_dv,
    input  logic                             req_write,
    input  logic [`MBOX_ADDR_W-1:0]          req_addr,
    input  logic [`MBOX_DATA_W-1:0]          req_wdata,
    input  logic                             soc_req,
    input  mbox_state_pkg::mbox_fsm_state_e  state,
    input  logic                             soc_has_lock,
    input  logic                             locked,
    input  logic                             owner_ok,
    input  logic                             pop,
    input  logic                             to_idle,
    input  logic [`MBOX_DATA_W-1:0]          dataout,
    output logic                             lock_rd,
    output logic                             cmd_wr,
    output logic                             dlen_wr,
    output logic                             datain_wr,
    output logic                             dataout_rd,
    output logic                             execute_wr,
    output logic                             unlock_wr,
    output mbox_bus_pkg::mbox_side_e         side,
    output logic                             execute_val,
    output logic [`MBOX_DATA_W-1:0]          wdata,
    output logic [31:0]                      dlen_bytes,
    output logic                             rsp_dv,
    output logic [`MBOX_DATA_W-1:0]          rdata,
    output logic                             mbox_error
);
    import mbox_bus_pkg::*;
    import mbox_state_pkg::*;

    mbox_reg_e               reg_sel;
    logic                    rd_req;
    logic                    wr_req;
    logic                    status_wr;
    logic                    bad_access;
    logic [`MBOX_DATA_W-1:0] cmd_q;
    logic [31:0]             dlen_q;
    mbox_cmd_status_e        status_q;
    logic [`MBOX_DATA_W-1:0] rd_val;

    // the low address bits are dropped, only the word offset selects
    always_comb begin
        case ({req_addr[`MBOX_ADDR_W-1:2], 2'b00})
            `MBOX_OFS_LOCK:    reg_sel = REG_LOCK;
            `MBOX_OFS_CMD:     reg_sel = REG_CMD;
            `MBOX_OFS_DLEN:    reg_sel = REG_DLEN;
            `MBOX_OFS_DATAIN:  reg_sel = REG_DATAIN;
            `MBOX_OFS_DATAOUT: reg_sel = REG_DATAOUT;
            `MBOX_OFS_EXECUTE: reg_sel = REG_EXECUTE;
            `MBOX_OFS_STATUS:  reg_sel = REG_STATUS;
            `MBOX_OFS_UNLOCK:  reg_sel = REG_UNLOCK;
            default:           reg_sel = REG_NONE;
        endcase
    end

    assign rd_req = req_dv & ~req_write;
    assign wr_req = req_dv & req_write;

    // one strobe per protocol access, ownership is judged in the FSM
    assign lock_rd    = rd_req & (reg_sel == REG_LOCK);
    assign cmd_wr     = wr_req & (reg_sel == REG_CMD);
    assign dlen_wr    = wr_req & (reg_sel == REG_DLEN);
    assign datain_wr  = wr_req & (reg_sel == REG_DATAIN);
    assign dataout_rd = rd_req & (reg_sel == REG_DATAOUT);
    assign execute_wr = wr_req & (reg_sel == REG_EXECUTE);
    assign unlock_wr  = wr_req & (reg_sel == REG_UNLOCK);
    assign status_wr  = wr_req & (reg_sel == REG_STATUS);

    // lock and dataout are read-only; unmapped offsets always fail
    assign bad_access = req_dv & ((reg_sel == REG_NONE) ||
                        (req_write && ((reg_sel == REG_LOCK) || (reg_sel == REG_DATAOUT))));

    assign side        = mbox_side_e'(soc_req);
    assign execute_val = req_wdata[0];
    assign wdata       = req_wdata;
    assign dlen_bytes  = dlen_q;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cmd_q    <= '0;
            dlen_q   <= '0;
            status_q <= CMD_BUSY;
        end else begin
            // only the lock holder may set up the message
            if (cmd_wr && owner_ok) begin
                cmd_q <= req_wdata;
            end
            if (dlen_wr && owner_ok) begin
                dlen_q <= req_wdata[31:0];
            end
            // either side may post a status; the return to idle resets it
            if (to_idle) begin
                status_q <= CMD_BUSY;
            end else if (status_wr) begin
                status_q <= mbox_cmd_status_e'(req_wdata[3:0]);
            end
        end
    end

    always_comb begin
        rd_val = '0;
        case (reg_sel)
            // a lock read reports the lock as it was before this access
            REG_LOCK:    rd_val[0] = locked;
            REG_CMD:     rd_val = cmd_q;
            REG_DLEN:    rd_val = dlen_q;
            // data only leaves the mailbox when the FSM grants the read
            REG_DATAOUT: rd_val = pop ? dataout : '0;
            REG_EXECUTE: rd_val[0] = (state == MBOX_EXECUTE_UC) || (state == MBOX_EXECUTE_SOC);
            REG_STATUS:  rd_val[7:0] = {soc_has_lock, state, status_q};
            default:     rd_val = '0;
        endcase
    end

    // response strobe and error flag come exactly one cycle after the request
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rsp_dv     <= 1'b0;
            mbox_error <= 1'b0;
        end else begin
            rsp_dv     <= req_dv;
            mbox_error <= bad_access;
        end
    end

    // write responses carry zero data
    always_ff @(posedge clk) begin
        rdata <= rd_req ? rd_val : '0;
    end

endmodule

/* hdl/mbox_buffer.sv */
// message word storage with write and read pointers
// reads stop advancing at the length given by dlen
`timescale 1ns/1ns

`include "mbox_consts.svh"

module mbox_buffer (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic                    push,
    input  logic                    pop,
    input  logic                    wr_clr,
    input  logic                    rd_clr,
    input  logic [`MBOX_DATA_W-1:0] wdata,
    input  logic [31:0]             dlen_bytes,
    output logic [`MBOX_DATA_W-1:0] dataout
);

    // index of the last word, where the write pointer parks
    localparam logic [`MBOX_PTR_W-1:0] last_idx = `MBOX_PTR_W'(`MBOX_DEPTH - 1);
    // buffer depth at the width of the length arithmetic
    localparam logic [31:0] depth_words = 32'(`MBOX_DEPTH);

    logic [`MBOX_DATA_W-1:0] mem [`MBOX_DEPTH];
    logic [`MBOX_PTR_W-1:0]  wr_ptr;
    logic [`MBOX_PTR_W-1:0]  rd_ptr;
    logic [31:0]             dlen_words;
    logic [31:0]             rd_limit;
    logic [31:0]             rd_next;
    logic                    rd_adv;

    // byte length rounded up to whole words
    assign dlen_words = (dlen_bytes >> 2) + {31'b0, |dlen_bytes[1:0]};

    // a length beyond the buffer is treated as a full buffer
    assign rd_limit = (dlen_words > depth_words) ? depth_words : dlen_words;

    // only move on while another valid word is left
    // so a read past the end sees the last word again
    assign rd_next = {{(32 - `MBOX_PTR_W){1'b0}}, rd_ptr} + 32'd1;
    assign rd_adv  = pop & (rd_next < rd_limit);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_clr) begin
                wr_ptr <= '0;
            end else if (push && (wr_ptr != last_idx)) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_clr) begin
                rd_ptr <= '0;
            end else if (rd_adv) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // once full, further pushes overwrite the last word
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // asynchronous read keeps the current word ready for the next dataout access
    assign dataout = mem[rd_ptr];

endmodule

/* hdl/mbox_fsm.sv */
// lock and protocol FSM of the mailbox
// checks which side owns the current phase and drives the buffer strobes
`timescale 1ns/1ns

module mbox_fsm (
    input  logic                            clk,
    input  logic                            rst_b,
    input  logic                            lock_rd,
    input  logic                            cmd_wr,
    input  logic                            dlen_wr,
    input  logic                            datain_wr,
    input  logic                            dataout_rd,
    input  logic                            execute_wr,
    input  logic                            unlock_wr,
    input  mbox_bus_pkg::mbox_side_e        side,
    input  logic                            execute_val,
    output mbox_state_pkg::mbox_fsm_state_e state,
    output logic                            soc_has_lock,
    output logic                            locked,
    output logic                            owner_ok,
    output logic                            push,
    output logic                            pop,
    output logic                            wr_clr,
    output logic                            rd_clr,
    output logic                            to_idle,
    output logic                            uc_data_avail,
    output logic                            soc_data_avail
);
    import mbox_bus_pkg::*;
    import mbox_state_pkg::*;

    mbox_fsm_state_e state_nxt;
    logic            in_exec;
    logic            sender;
    logic            receiver;
    logic            phase_ok;
    logic            lock_take;
    logic            release_req;

    // the mailbox counts as locked in every state except idle
    assign locked  = (state != MBOX_IDLE);
    assign in_exec = (state == MBOX_EXECUTE_UC) || (state == MBOX_EXECUTE_SOC);

    // the sender is the side that took the lock
    assign sender = locked & ((side == SIDE_SOC) == soc_has_lock);

    // in an execute state only the side the data is meant for may touch it
    assign receiver = ((state == MBOX_EXECUTE_UC) && (side == SIDE_UC)) ||
                      ((state == MBOX_EXECUTE_SOC) && (side == SIDE_SOC));

    // cmd and dlen belong to the sender while the message is being set up
    assign owner_ok = sender & ~in_exec;

    // whoever owns the present phase may also clear execute
    assign phase_ok = in_exec ? receiver : owner_ok;

    // clearing execute ends the transfer; a force unlock works from anywhere
    assign release_req = unlock_wr | (execute_wr & ~execute_val & phase_ok);

    always_comb begin
        state_nxt = state;
        lock_take = 1'b0;
        push      = 1'b0;
        pop       = 1'b0;
        wr_clr    = 1'b0;
        rd_clr    = 1'b0;
        to_idle   = 1'b0;
        case (state)
            MBOX_IDLE: begin
                // the first lock read wins the mailbox
                if (lock_rd) begin
                    state_nxt = MBOX_RDY_FOR_CMD;
                    lock_take = 1'b1;
                end
            end
            MBOX_RDY_FOR_CMD: begin
                if (cmd_wr && owner_ok) begin
                    state_nxt = MBOX_RDY_FOR_DLEN;
                end
            end
            MBOX_RDY_FOR_DLEN: begin
                if (dlen_wr && owner_ok) begin
                    state_nxt = MBOX_RDY_FOR_DATA;
                end
            end
            MBOX_RDY_FOR_DATA: begin
                push = datain_wr & owner_ok;
                // hand the message to the other side
                // the write pointer restarts so the receiver can answer in place
                if (execute_wr && owner_ok && execute_val) begin
                    state_nxt = soc_has_lock ? MBOX_EXECUTE_UC : MBOX_EXECUTE_SOC;
                    wr_clr    = 1'b1;
                end
            end
            MBOX_EXECUTE_UC, MBOX_EXECUTE_SOC: begin
                push = datain_wr & receiver;
                pop  = dataout_rd & receiver;
            end
            default: begin
                state_nxt = MBOX_IDLE;
            end
        endcase
        // a release overrides whatever the state asked for
        if (release_req) begin
            state_nxt = MBOX_IDLE;
            push      = 1'b0;
            pop       = 1'b0;
            wr_clr    = 1'b1;
            rd_clr    = 1'b1;
            to_idle   = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state        <= MBOX_IDLE;
            soc_has_lock <= 1'b0;
        end else begin
            state <= state_nxt;
            // remember which side locked, and forget it once released
            if (lock_take) begin
                soc_has_lock <= (side == SIDE_SOC);
            end else if (to_idle) begin
                soc_has_lock <= 1'b0;
            end
        end
    end

    // data-available levels follow the execute states directly
    assign uc_data_avail  = (state == MBOX_EXECUTE_UC);
    assign soc_data_avail = (state == MBOX_EXECUTE_SOC);

endmodule

/* hdl/mbox_state_pkg.sv */
// protocol types: mailbox states and the command status codes
package mbox_state_pkg;

    // protocol states of the mailbox
    // neighbouring setup states differ in one bit
    typedef enum logic [2:0] {
        MBOX_IDLE         = 3'b000,
        MBOX_RDY_FOR_CMD  = 3'b001,
        MBOX_RDY_FOR_DLEN = 3'b011,
        MBOX_RDY_FOR_DATA = 3'b010,
        MBOX_EXECUTE_UC   = 3'b110,
        MBOX_EXECUTE_SOC  = 3'b100
    } mbox_fsm_state_e;

    // status written back by the receiver of a message
    // busy is also the value after every return to idle
    typedef enum logic [3:0] {
        CMD_BUSY     = 4'd0,
        DATA_READY   = 4'd1,
        CMD_COMPLETE = 4'd2,
        CMD_FAILURE  = 4'd3
    } mbox_cmd_status_e;

endpackage

/* hdl/mbox_bus_pkg.sv */
// register bus types: register select decoded from the offset
// and the side of the requester
package mbox_bus_pkg;

    // one value per mapped register
    // anything else on the bus decodes to REG_NONE and gets an error
    typedef enum logic [3:0] {
        REG_LOCK    = 4'd0,
        REG_CMD     = 4'd1,
        REG_DLEN    = 4'd2,
        REG_DATAIN  = 4'd3,
        REG_DATAOUT = 4'd4,
        REG_EXECUTE = 4'd5,
        REG_STATUS  = 4'd6,
        REG_UNLOCK  = 4'd7,
        REG_NONE    = 4'd15
    } mbox_reg_e;

    // the two requesters share one bus
    // the encoding follows the soc_req input so a plain cast is enough
    typedef enum logic {
        SIDE_UC  = 1'b0,
        SIDE_SOC = 1'b1
    } mbox_side_e;

endpackage

/* hdl/mbox_consts.svh */
// sizing macros and register byte offsets for the message mailbox
`ifndef MBOX_CONSTS_SVH
`define MBOX_CONSTS_SVH

// width of one data word on the register bus and in the buffer
`define MBOX_DATA_W 32

// message buffer holds this many words
`define MBOX_DEPTH 64

// pointer width must cover every word of the buffer
`define MBOX_PTR_W 6

// byte address width of the register bus
`define MBOX_ADDR_W 6

// byte offsets of the mailbox registers, all word aligned
`define MBOX_OFS_LOCK    6'h00
`define MBOX_OFS_CMD     6'h08
`define MBOX_OFS_DLEN    6'h0C
`define MBOX_OFS_DATAIN  6'h10
`define MBOX_OFS_DATAOUT 6'h14
`define MBOX_OFS_EXECUTE 6'h18
`define MBOX_OFS_STATUS  6'h1C
// force unlock sits past the status register
`define MBOX_OFS_UNLOCK  6'h20

`endif
